/* verilog/proc_macros.svh */
`ifndef PROC_MACROS_SVH
`define PROC_MACROS_SVH

// Primary opcodes, instruction bits [15:11]
`define PROC_OP_HALT   5'b00000
`define PROC_OP_NOP    5'b00001
`define PROC_OP_J      5'b00100
`define PROC_OP_ADDI   5'b01000
`define PROC_OP_BEQZ   5'b01100
`define PROC_OP_BNEZ   5'b01101
`define PROC_OP_ST     5'b10000
`define PROC_OP_LD     5'b10001

// Register-register group, operation picked by fn
`define PROC_OP_RTYPE  5'b11011

// R-format function codes, instruction bits [1:0]
`define PROC_FN_ADD    2'b00
`define PROC_FN_SUB    2'b01
`define PROC_FN_XOR    2'b10
`define PROC_FN_AND    2'b11

// Word address widths of the two 64-entry memories
`define PROC_IMEM_AW   6
`define PROC_DMEM_AW   6

`endif

/* verilog/proc_pkg.sv */
package proc_pkg;

   // Register-register layout
   typedef struct packed {
      logic [4:0] op;
      logic [2:0] rs;
      logic [2:0] rt;
      logic [2:0] rd;
      logic [1:0] fn;
   } instr_fmt_r_t;

   // Immediate layout, also used by branches and J with rd ignored
   typedef struct packed {
      logic [4:0]        op;
      logic [2:0]        rs;
      logic [2:0]        rd;
      logic signed [4:0] imm;
   } instr_fmt_i_t;

   // One 16-bit instruction word, two decodings
   typedef union packed {
      instr_fmt_r_t r;
      instr_fmt_i_t i;
   } instr_u;

endpackage

/* verilog/fetch.sv */
`timescale 1ns/1ps
`include "proc_macros.svh"

module fetch import proc_pkg::*; (
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     load_en_i,
   input  logic [`PROC_IMEM_AW-1:0] load_addr_i,
   input  logic [15:0]              load_instr_i,
   input  logic                     stall_id_i,
   input  logic                     redirect_i,
   input  logic [15:0]              redirect_pc_i,
   input  logic                     halt_id_i,
   output logic                     id_valid_o,
   output instr_u                   id_instr_o,
   output logic [15:0]              id_pc_inc_o
);

   logic [15:0] imem [0:(1 << `PROC_IMEM_AW)-1];
   logic [15:0] pc;
   logic        halted;

   // Program load, accepted only while the core is held in reset
   always_ff @(posedge clk_i) begin
      if (rst_i && load_en_i) begin
         imem[load_addr_i] <= load_instr_i;
      end
   end

   // PC and IF/ID valid
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         pc         <= 16'd0;
         halted     <= 1'b0;
         id_valid_o <= 1'b0;
      end else if (halted || halt_id_i) begin
         // No more issue once HALT reaches decode
         halted     <= 1'b1;
         id_valid_o <= 1'b0;
      end else if (redirect_i) begin
         // Taken branch or jump, drop the word fetched behind it
         pc         <= redirect_pc_i;
         id_valid_o <= 1'b0;
      end else if (!stall_id_i) begin
         pc         <= pc + 16'd1;
         id_valid_o <= 1'b1;
      end
   end

   // IF/ID payload, held while decode stalls
   always_ff @(posedge clk_i) begin
      if (!stall_id_i) begin
         id_instr_o  <= imem[pc[`PROC_IMEM_AW-1:0]];
         id_pc_inc_o <= pc + 16'd1;
      end
   end

endmodule

/* verilog/decode.sv */
`timescale 1ns/1ps
`include "proc_macros.svh"

module decode import proc_pkg::*; (
   input  logic        clk_i,
   input  logic        rst_i,
   input  logic        id_valid_i,
   input  instr_u      id_instr_i,
   input  logic [15:0] id_pc_inc_i,
   input  logic        wb_en_i,
   input  logic [2:0]  wb_reg_i,
   input  logic [15:0] wb_data_i,
   input  logic        mem_wr_en_i,
   input  logic [2:0]  mem_rd_i,
   output logic        stall_id_o,
   output logic        redirect_o,
   output logic [15:0] redirect_pc_o,
   output logic        halt_id_o,
   output logic        ex_valid_o,
   output logic [1:0]  ex_fn_o,
   output logic        ex_use_imm_o,
   output logic [15:0] ex_a_o,
   output logic [15:0] ex_b_o,
   output logic [4:0]  ex_imm_o,
   output logic [2:0]  ex_rd_o,
   output logic        ex_wr_en_o,
   output logic        ex_ld_o,
   output logic        ex_st_o,
   output logic        ex_halt_o,
   output logic        ex_illegal_o
);

   logic [15:0] regs [0:7];
   logic [4:0]  op;
   logic        is_rtype;
   logic        is_addi;
   logic        is_ld;
   logic        is_st;
   logic        is_beqz;
   logic        is_bnez;
   logic        is_j;
   logic        is_halt;
   logic        is_nop;
   logic        is_illegal;
   logic [2:0]  src_a;
   logic [2:0]  src_b;
   logic [2:0]  dst;
   logic        use_a;
   logic        use_b;
   logic        writes;
   logic        hazard_a;
   logic        hazard_b;
   logic [15:0] val_a;
   logic [15:0] val_b;
   logic        taken;
   logic        issue;

   // Opcode sits in the same bits of both views
   assign op         = id_instr_i.r.op;
   assign is_rtype   = op == `PROC_OP_RTYPE;
   assign is_addi    = op == `PROC_OP_ADDI;
   assign is_ld      = op == `PROC_OP_LD;
   assign is_st      = op == `PROC_OP_ST;
   assign is_beqz    = op == `PROC_OP_BEQZ;
   assign is_bnez    = op == `PROC_OP_BNEZ;
   assign is_j       = op == `PROC_OP_J;
   assign is_halt    = op == `PROC_OP_HALT;
   assign is_nop     = op == `PROC_OP_NOP;
   assign is_illegal = !(is_rtype || is_addi || is_ld || is_st || is_beqz ||
                         is_bnez || is_j || is_halt || is_nop);

   // Both source fields share their bits across the two views
   assign src_a = id_instr_i.r.rs;
   // ST reads its data register from these bits too
   assign src_b = id_instr_i.r.rt;

   // Destination through the view the opcode selects
   assign dst = is_rtype ? id_instr_i.r.rd : id_instr_i.i.rd;

   assign use_a  = is_rtype || is_addi || is_ld || is_st || is_beqz || is_bnez;
   assign use_b  = is_rtype || is_st;
   assign writes = is_rtype || is_addi || is_ld;

   // RAW check against the two boundaries still ahead of writeback
   assign hazard_a = use_a && ((ex_wr_en_o && ex_rd_o == src_a) ||
                               (mem_wr_en_i && mem_rd_i == src_a));
   assign hazard_b = use_b && ((ex_wr_en_o && ex_rd_o == src_b) ||
                               (mem_wr_en_i && mem_rd_i == src_b));

   assign stall_id_o = id_valid_i && (hazard_a || hazard_b);
   assign issue      = id_valid_i && !stall_id_o;
   assign halt_id_o  = id_valid_i && is_halt;

   // Register file with the value being written seen in the same cycle
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= 16'd0;
         end
      end else if (wb_en_i) begin
         regs[wb_reg_i] <= wb_data_i;
      end
   end

   assign val_a = (wb_en_i && wb_reg_i == src_a) ? wb_data_i : regs[src_a];
   assign val_b = (wb_en_i && wb_reg_i == src_b) ? wb_data_i : regs[src_b];

   // Branch resolution
   assign taken = is_j || (is_beqz && val_a == 16'd0) || (is_bnez && val_a != 16'd0);
   assign redirect_o    = issue && taken;
   assign redirect_pc_o = id_pc_inc_i + {{11{id_instr_i.i.imm[4]}}, id_instr_i.i.imm};

   // ID/EX control gets a bubble on stall or empty IF/ID
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ex_valid_o   <= 1'b0;
         ex_wr_en_o   <= 1'b0;
         ex_ld_o      <= 1'b0;
         ex_st_o      <= 1'b0;
         ex_halt_o    <= 1'b0;
         ex_illegal_o <= 1'b0;
      end else begin
         ex_valid_o   <= issue;
         ex_wr_en_o   <= issue && writes;
         ex_ld_o      <= issue && is_ld;
         ex_st_o      <= issue && is_st;
         ex_halt_o    <= issue && is_halt;
         ex_illegal_o <= issue && is_illegal;
      end
   end

   // ID/EX payload
   always_ff @(posedge clk_i) begin
      ex_fn_o      <= is_rtype ? id_instr_i.r.fn : `PROC_FN_ADD;
      ex_use_imm_o <= !is_rtype;
      ex_a_o       <= val_a;
      ex_b_o       <= val_b;
      ex_imm_o     <= id_instr_i.i.imm;
      ex_rd_o      <= dst;
   end

endmodule

/* verilog/execute.sv */
`timescale 1ns/1ps
`include "proc_macros.svh"

module execute (
   input  logic        clk_i,
   input  logic        rst_i,
   input  logic        ex_valid_i,
   input  logic [1:0]  ex_fn_i,
   input  logic        ex_use_imm_i,
   input  logic [15:0] ex_a_i,
   input  logic [15:0] ex_b_i,
   input  logic [4:0]  ex_imm_i,
   input  logic [2:0]  ex_rd_i,
   input  logic        ex_wr_en_i,
   input  logic        ex_ld_i,
   input  logic        ex_st_i,
   input  logic        ex_halt_i,
   input  logic        ex_illegal_i,
   output logic        mem_valid_o,
   output logic [15:0] mem_result_o,
   output logic [15:0] mem_store_data_o,
   output logic [2:0]  mem_rd_o,
   output logic        mem_wr_en_o,
   output logic        mem_ld_o,
   output logic        mem_st_o,
   output logic        mem_halt_o,
   output logic        mem_illegal_o
);

   logic [15:0] op_b;
   logic [15:0] alu_res;

   // Second operand is a register or the sign-extended immediate
   assign op_b = ex_use_imm_i ? {{11{ex_imm_i[4]}}, ex_imm_i} : ex_b_i;

   always_comb begin
      case (ex_fn_i)
         `PROC_FN_ADD: alu_res = ex_a_i + op_b;
         `PROC_FN_SUB: alu_res = ex_a_i - op_b;
         `PROC_FN_AND: alu_res = ex_a_i & op_b;
         `PROC_FN_XOR: alu_res = ex_a_i ^ op_b;
         default:      alu_res = ex_a_i + op_b;
      endcase
   end

   // EX/MEM control
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         mem_valid_o   <= 1'b0;
         mem_wr_en_o   <= 1'b0;
         mem_ld_o      <= 1'b0;
         mem_st_o      <= 1'b0;
         mem_halt_o    <= 1'b0;
         mem_illegal_o <= 1'b0;
      end else begin
         mem_valid_o   <= ex_valid_i;
         mem_wr_en_o   <= ex_wr_en_i;
         mem_ld_o      <= ex_ld_i;
         mem_st_o      <= ex_st_i;
         mem_halt_o    <= ex_halt_i;
         mem_illegal_o <= ex_illegal_i;
      end
   end

   // EX/MEM payload with the rd value as store data
   always_ff @(posedge clk_i) begin
      mem_result_o     <= alu_res;
      mem_store_data_o <= ex_b_i;
      mem_rd_o         <= ex_rd_i;
   end

endmodule

/* verilog/memory.sv */
`timescale 1ns/1ps
`include "proc_macros.svh"

module memory (
   input  logic        clk_i,
   input  logic        rst_i,
   input  logic        mem_valid_i,
   input  logic [15:0] mem_result_i,
   input  logic [15:0] mem_store_data_i,
   input  logic [2:0]  mem_rd_i,
   input  logic        mem_wr_en_i,
   input  logic        mem_ld_i,
   input  logic        mem_st_i,
   input  logic        mem_halt_i,
   input  logic        mem_illegal_i,
   output logic        wb_en_o,
   output logic [2:0]  wb_reg_o,
   output logic [15:0] wb_data_o,
   output logic        halt_o,
   output logic        err_o
);

   logic [15:0]              dmem [0:(1 << `PROC_DMEM_AW)-1];
   logic [`PROC_DMEM_AW-1:0] addr;

   // Word address from the low bits of the ALU result
   assign addr = mem_result_i[`PROC_DMEM_AW-1:0];

   always_ff @(posedge clk_i) begin
      if (mem_valid_i && mem_st_i) begin
         dmem[addr] <= mem_store_data_i;
      end
   end

   // Load read lands directly in MEM/WB
   always_ff @(posedge clk_i) begin
      wb_reg_o  <= mem_rd_i;
      wb_data_o <= mem_ld_i ? dmem[addr] : mem_result_i;
   end

   // Retirement flags, halt is sticky until reset
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wb_en_o <= 1'b0;
         halt_o  <= 1'b0;
         err_o   <= 1'b0;
      end else begin
         wb_en_o <= mem_valid_i && mem_wr_en_i;
         halt_o  <= halt_o || (mem_valid_i && mem_halt_i);
         err_o   <= mem_valid_i && mem_illegal_i;
      end
   end

endmodule

/* verilog/proc.sv */
`timescale 1ns/1ps
`include "proc_macros.svh"

module proc import proc_pkg::*; (
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     load_en_i,
   input  logic [`PROC_IMEM_AW-1:0] load_addr_i,
   input  logic [15:0]              load_instr_i,
   output logic                     wb_en_o,
   output logic [2:0]               wb_reg_o,
   output logic [15:0]              wb_data_o,
   output logic                     halt_o,
   output logic                     err_o
);

   // IF/ID
   logic        id_valid;
   instr_u      id_instr;
   logic [15:0] id_pc_inc;

   // Decode feedback to fetch
   logic        stall_id;
   logic        redirect;
   logic [15:0] redirect_pc;
   logic        halt_id;

   // ID/EX
   logic        ex_valid;
   logic [1:0]  ex_fn;
   logic        ex_use_imm;
   logic [15:0] ex_a;
   logic [15:0] ex_b;
   logic [4:0]  ex_imm;
   logic [2:0]  ex_rd;
   logic        ex_wr_en;
   logic        ex_ld;
   logic        ex_st;
   logic        ex_halt;
   logic        ex_illegal;

   // EX/MEM
   logic        mem_valid;
   logic [15:0] mem_result;
   logic [15:0] mem_store_data;
   logic [2:0]  mem_rd;
   logic        mem_wr_en;
   logic        mem_ld;
   logic        mem_st;
   logic        mem_halt;
   logic        mem_illegal;

   fetch fetch_i (
      .clk_i(clk_i), .rst_i(rst_i), .load_en_i(load_en_i), .load_addr_i(load_addr_i),
      .load_instr_i(load_instr_i), .stall_id_i(stall_id), .redirect_i(redirect),
      .redirect_pc_i(redirect_pc), .halt_id_i(halt_id), .id_valid_o(id_valid),
      .id_instr_o(id_instr), .id_pc_inc_o(id_pc_inc));

   // Writeback results loop back into the register file
   decode decode_i (
      .clk_i(clk_i), .rst_i(rst_i), .id_valid_i(id_valid), .id_instr_i(id_instr),
      .id_pc_inc_i(id_pc_inc), .wb_en_i(wb_en_o), .wb_reg_i(wb_reg_o), .wb_data_i(wb_data_o),
      .mem_wr_en_i(mem_wr_en), .mem_rd_i(mem_rd), .stall_id_o(stall_id),
      .redirect_o(redirect), .redirect_pc_o(redirect_pc), .halt_id_o(halt_id),
      .ex_valid_o(ex_valid), .ex_fn_o(ex_fn), .ex_use_imm_o(ex_use_imm), .ex_a_o(ex_a),
      .ex_b_o(ex_b), .ex_imm_o(ex_imm), .ex_rd_o(ex_rd), .ex_wr_en_o(ex_wr_en),
      .ex_ld_o(ex_ld), .ex_st_o(ex_st), .ex_halt_o(ex_halt), .ex_illegal_o(ex_illegal));

   execute execute_i (
      .clk_i(clk_i), .rst_i(rst_i), .ex_valid_i(ex_valid), .ex_fn_i(ex_fn),
      .ex_use_imm_i(ex_use_imm), .ex_a_i(ex_a), .ex_b_i(ex_b), .ex_imm_i(ex_imm),
      .ex_rd_i(ex_rd), .ex_wr_en_i(ex_wr_en), .ex_ld_i(ex_ld), .ex_st_i(ex_st),
      .ex_halt_i(ex_halt), .ex_illegal_i(ex_illegal), .mem_valid_o(mem_valid),
      .mem_result_o(mem_result), .mem_store_data_o(mem_store_data), .mem_rd_o(mem_rd),
      .mem_wr_en_o(mem_wr_en), .mem_ld_o(mem_ld), .mem_st_o(mem_st),
      .mem_halt_o(mem_halt), .mem_illegal_o(mem_illegal));

   memory memory_i (
      .clk_i(clk_i), .rst_i(rst_i), .mem_valid_i(mem_valid), .mem_result_i(mem_result),
      .mem_store_data_i(mem_store_data), .mem_rd_i(mem_rd), .mem_wr_en_i(mem_wr_en),
      .mem_ld_i(mem_ld), .mem_st_i(mem_st), .mem_halt_i(mem_halt),
      .mem_illegal_i(mem_illegal), .wb_en_o(wb_en_o), .wb_reg_o(wb_reg_o),
      .wb_data_o(wb_data_o), .halt_o(halt_o), .err_o(err_o));

endmodule

/* verif/proc_assertions.sv */
`timescale 1ns/1ps

module proc_assertions (
   input logic clk_i,
   input logic rst_i,
   input logic wb_en_i,
   input logic halt_i,
   input logic err_i
);

   // Retirement outputs come out of reset low
   reset_clears: assert property (@(posedge clk_i) rst_i |=> !wb_en_i && !halt_i && !err_i)
      else $error("retirement outputs not low one cycle into reset");

   // Halt is sticky until the next reset
   halt_sticky: assert property (@(posedge clk_i) halt_i && !rst_i |=> halt_i)
      else $error("halt_o fell while reset was low");

   no_wb_when_halted: assert property (@(posedge clk_i) disable iff (rst_i)
      !(wb_en_i && halt_i))
      else $error("wb_en_o high while halt_o is high");

   err_pulse: assert property (@(posedge clk_i) disable iff (rst_i) err_i |=> !err_i)
      else $error("err_o held for more than one cycle");

endmodule

/* verif/proc_tb.sv */
`timescale 1ns/1ps
`include "proc_macros.svh"

module proc_tb import proc_pkg::*; ();

   logic                     clk_i;
   logic                     rst_i;
   logic                     load_en_i;
   logic [`PROC_IMEM_AW-1:0] load_addr_i;
   logic [15:0]              load_instr_i;
   logic                     wb_en_o;
   logic [2:0]               wb_reg_o;
   logic [15:0]              wb_data_o;
   logic                     halt_o;
   logic                     err_o;

   logic [15:0] prog [0:63];
   int          prog_len;
   logic        exp_err [$];
   logic [2:0]  exp_reg [$];
   logic [15:0] exp_data [$];
   int          value_errors;
   int          other_errors;

   proc proc_i (
      .clk_i(clk_i), .rst_i(rst_i), .load_en_i(load_en_i), .load_addr_i(load_addr_i),
      .load_instr_i(load_instr_i), .wb_en_o(wb_en_o), .wb_reg_o(wb_reg_o),
      .wb_data_o(wb_data_o), .halt_o(halt_o), .err_o(err_o));

   bind proc proc_assertions proc_assertions_i (
      .clk_i(clk_i), .rst_i(rst_i), .wb_en_i(wb_en_o), .halt_i(halt_o), .err_i(err_o));

   always #20 clk_i = ~clk_i;

   function automatic logic [15:0] encode_rtype(logic [1:0] fn, int rd, int rs, int rt);
      instr_u w;
      w.r.op = `PROC_OP_RTYPE;
      w.r.rs = 3'(rs);
      w.r.rt = 3'(rt);
      w.r.rd = 3'(rd);
      w.r.fn = fn;
      return w;
   endfunction

   function automatic logic [15:0] encode_imm(logic [4:0] op, int rd, int rs, int imm);
      instr_u w;
      w.i.op  = op;
      w.i.rs  = 3'(rs);
      w.i.rd  = 3'(rd);
      w.i.imm = 5'(imm);
      return w;
   endfunction

   // Unused words are HALT with the address in the low bits
   function automatic void clear_program();
      for (int a = 0; a < 64; a++) begin
         prog[6'(a)] = {`PROC_OP_HALT, 5'd0, 6'(a)};
      end
      prog_len = 0;
   endfunction

   function automatic void emit(logic [15:0] word);
      prog[6'(prog_len)] = word;
      prog_len++;
   endfunction

   function automatic void add_expected(logic is_err, logic [2:0] rd, logic [15:0] data);
      exp_err.push_back(is_err);
      exp_reg.push_back(rd);
      exp_data.push_back(data);
   endfunction

   // ISA-level walk of the program, one retirement event per write or illegal word
   task automatic predict_retirements();
      logic [15:0] rf [0:7];
      logic [15:0] dm [0:63];
      logic [15:0] pc;
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] imm;
      logic [15:0] res;
      instr_u      w;
      int          steps;
      bit          done;
      exp_err.delete();
      exp_reg.delete();
      exp_data.delete();
      for (int k = 0; k < 8; k++) begin
         rf[3'(k)] = 16'd0;
      end
      pc = 16'd0;
      steps = 0;
      done = 1'b0;
      while (!done && steps < 500) begin
         w = prog[pc[5:0]];
         // rs sits in the same bits of both formats
         a = rf[w.i.rs];
         b = rf[w.r.rt];
         imm = {{11{w.i.imm[4]}}, w.i.imm};
         res = a + imm;
         pc = pc + 16'd1;
         steps++;
         case (w.r.op)
            `PROC_OP_HALT: done = 1'b1;
            `PROC_OP_NOP: ;
            `PROC_OP_BEQZ: if (a == 16'd0) pc = pc + imm;
            `PROC_OP_BNEZ: if (a != 16'd0) pc = pc + imm;
            `PROC_OP_J: pc = pc + imm;
            `PROC_OP_ST: dm[res[5:0]] = rf[w.i.rd];
            `PROC_OP_ADDI: begin
               rf[w.i.rd] = res;
               add_expected(1'b0, w.i.rd, res);
            end
            `PROC_OP_LD: begin
               rf[w.i.rd] = dm[res[5:0]];
               add_expected(1'b0, w.i.rd, dm[res[5:0]]);
            end
            `PROC_OP_RTYPE: begin
               case (w.r.fn)
                  `PROC_FN_ADD: res = a + b;
                  `PROC_FN_SUB: res = a - b;
                  `PROC_FN_AND: res = a & b;
                  `PROC_FN_XOR: res = a ^ b;
               endcase
               rf[w.r.rd] = res;
               add_expected(1'b0, w.r.rd, res);
            end
            default: add_expected(1'b1, 3'd0, 16'd0);
         endcase
      end
   endtask

   task automatic check_reg(string name, logic [2:0] expected, logic [2:0] actual);
      if (actual !== expected) begin
         value_errors++;
         $display("[ERROR] %s: wb_reg_o expected %0d, actual %0d", name, expected, actual);
      end
   endtask

   task automatic check_data(string name, logic [15:0] expected, logic [15:0] actual);
      if (actual !== expected) begin
         value_errors++;
         $display("[ERROR] %s: wb_data_o expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic check_flag(string name, string what, logic expected, logic actual);
      if (actual !== expected) begin
         value_errors++;
         $display("[ERROR] %s: %s expected %b, actual %b", name, what, expected, actual);
      end
   endtask

   task automatic compare_retirement(string name);
      if (exp_err.size() == 0) begin
         other_errors++;
         $display("%s: an instruction retired that the program never reaches", name);
      end else begin
         check_flag(name, "err_o", exp_err[0], err_o);
         check_flag(name, "wb_en_o", !exp_err[0], wb_en_o);
         if (!exp_err[0]) begin
            check_reg(name, exp_reg[0], wb_reg_o);
            check_data(name, exp_data[0], wb_data_o);
         end
         void'(exp_err.pop_front());
         void'(exp_reg.pop_front());
         void'(exp_data.pop_front());
      end
   endtask

   task automatic run_program(string name);
      int cycles;
      bit halted;
      predict_retirements();
      @(posedge clk_i);
      rst_i <= 1'b1;
      // Whole instruction memory rewritten while the core sits in reset
      for (int a = 0; a < 64; a++) begin
         @(posedge clk_i);
         load_en_i    <= 1'b1;
         load_addr_i  <= 6'(a);
         load_instr_i <= prog[6'(a)];
      end
      @(posedge clk_i);
      load_en_i <= 1'b0;
      @(posedge clk_i);
      rst_i <= 1'b0;
      cycles = 0;
      halted = 1'b0;
      while (!halted && cycles < 600) begin
         @(negedge clk_i);
         cycles++;
         if (wb_en_o || err_o) begin
            compare_retirement(name);
         end
         halted = halt_o;
      end
      if (!halted) begin
         other_errors++;
         $display("%s: halt_o did not rise within %0d cycles", name, cycles);
      end else begin
         if (exp_err.size() != 0) begin
            other_errors++;
            $display("%s: halt_o rose with %0d instructions not retired", name, exp_err.size());
         end
         // Nothing behind HALT may retire
         for (int c = 0; c < 20; c++) begin
            @(negedge clk_i);
            check_flag(name, "wb_en_o", 1'b0, wb_en_o);
            check_flag(name, "err_o", 1'b0, err_o);
            check_flag(name, "halt_o", 1'b1, halt_o);
         end
      end
   endtask

   // Each step reads the result of the one before
   task automatic alu_chain();
      clear_program();
      emit(encode_imm(`PROC_OP_ADDI, 1, 0, 7));
      emit(encode_imm(`PROC_OP_ADDI, 2, 1, -3));
      emit(encode_rtype(`PROC_FN_ADD, 3, 1, 2));
      emit(encode_rtype(`PROC_FN_SUB, 4, 2, 3));
      emit(encode_rtype(`PROC_FN_AND, 5, 4, 3));
      emit(encode_rtype(`PROC_FN_XOR, 6, 5, 1));
      run_program("alu_chain");
   endtask

   task automatic load_store();
      clear_program();
      emit(encode_imm(`PROC_OP_ADDI, 1, 0, 5));
      emit(encode_imm(`PROC_OP_ADDI, 2, 0, -6));
      emit(encode_imm(`PROC_OP_ADDI, 3, 0, 12));
      emit(encode_imm(`PROC_OP_ST, 1, 0, 2));
      emit(encode_imm(`PROC_OP_ST, 2, 3, 1));
      emit(encode_imm(`PROC_OP_ST, 3, 0, 3));
      emit(encode_imm(`PROC_OP_LD, 4, 0, 2));
      emit(encode_rtype(`PROC_FN_ADD, 5, 4, 1));
      emit(encode_imm(`PROC_OP_LD, 6, 3, 1));
      emit(encode_rtype(`PROC_FN_ADD, 7, 6, 4));
      emit(encode_imm(`PROC_OP_LD, 4, 0, 3));
      emit(encode_rtype(`PROC_FN_ADD, 5, 4, 5));
      run_program("load_store");
   endtask

   // Skipped words all write 9, so a leak shows up as an extra retirement
   task automatic branches();
      clear_program();
      emit(encode_imm(`PROC_OP_ADDI, 1, 0, 3));
      emit(encode_imm(`PROC_OP_BEQZ, 0, 1, 2));
      emit(encode_imm(`PROC_OP_ADDI, 2, 0, 1));
      emit(encode_imm(`PROC_OP_BNEZ, 0, 1, 1));
      emit(encode_imm(`PROC_OP_ADDI, 3, 0, 9));
      emit(encode_imm(`PROC_OP_BEQZ, 0, 0, 1));
      emit(encode_imm(`PROC_OP_ADDI, 4, 0, 9));
      emit(encode_imm(`PROC_OP_BNEZ, 0, 0, 3));
      emit(encode_imm(`PROC_OP_J, 0, 0, 2));
      emit(encode_imm(`PROC_OP_ADDI, 5, 0, 9));
      emit(encode_imm(`PROC_OP_ADDI, 6, 0, 9));
      emit(encode_imm(`PROC_OP_ADDI, 7, 2, 4));
      // Countdown loop, backward BNEZ on a just-written register
      emit(encode_imm(`PROC_OP_ADDI, 1, 1, -1));
      emit(encode_imm(`PROC_OP_BNEZ, 0, 1, -2));
      run_program("branches");
   endtask

   task automatic halt_stop();
      clear_program();
      emit(encode_imm(`PROC_OP_ADDI, 1, 0, 4));
      emit(encode_imm(`PROC_OP_ADDI, 2, 1, 5));
      emit(encode_imm(`PROC_OP_HALT, 0, 0, 0));
      emit(encode_imm(`PROC_OP_ADDI, 3, 0, 1));
      emit(encode_imm(`PROC_OP_ADDI, 4, 0, 2));
      run_program("halt_stop");
   endtask

   task automatic illegal_opcode();
      clear_program();
      emit(encode_imm(`PROC_OP_ADDI, 1, 0, 2));
      emit(encode_imm(5'b11111, 1, 1, 7));
      emit(encode_imm(`PROC_OP_ADDI, 2, 1, 3));
      emit(encode_rtype(`PROC_FN_ADD, 3, 2, 1));
      run_program("illegal_opcode");
   endtask

   task automatic random_program();
      clear_program();
      for (int n = 0; n < 24; n++) begin
         if ($urandom % 2 == 0) begin
            emit(encode_imm(`PROC_OP_ADDI, $urandom, $urandom, $urandom));
         end else begin
            emit(encode_rtype(2'($urandom), $urandom, $urandom, $urandom));
         end
      end
      run_program("random_program");
   endtask

   initial begin
      clk_i = 1'b0;
      rst_i = 1'b1;
      load_en_i = 1'b0;
      load_addr_i = '0;
      load_instr_i = 16'd0;
      value_errors = 0;
      other_errors = 0;
      void'($urandom(32'h757b_9efd));
      repeat (16) @(posedge clk_i);
      alu_chain();
      load_store();
      branches();
      halt_stop();
      illegal_opcode();
      random_program();
      $display("Checks done: %0d value errors, %0d other failures", value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

/* files.f */
+incdir+verilog
verilog/proc_pkg.sv
verilog/fetch.sv
verilog/decode.sv
verilog/execute.sv
verilog/memory.sv
verilog/proc.sv
verif/proc_assertions.sv
verif/proc_tb.sv

/* Makefile */
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f files.f --top-module proc_tb

run: compile
	@out="$$(./obj_dir/Vproc_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir
